// File: list.f
hw/cl_regbus_pkg.sv
hw/cl_irq_pkg.sv
hw/cl_regbus_demux.sv
hw/bus_err_unit.sv
hw/cl_irq_ctrl.sv
hw/core_local_periph.sv
testbench/core_local_periph_props.sv
testbench/tb_core_local_periph.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_core_local_periph
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_core_local_periph.sv
/*
  Random testbench with a cycle model of the complex, seeded once with 73931.
  Register responses and interrupt outputs are compared at the falling edge.
*/
`timescale 1ns/1ps

module tb_core_local_periph;
  import cl_regbus_pkg::*;
  import cl_irq_pkg::*;

  logic                     clk_i;
  logic                     reset_i;
  reg_req_t                 cl_req;
  reg_rsp_t                 cl_rsp;
  logic                     bus_req [2];
  logic                     bus_gnt [2];
  logic                     bus_rvalid [2];
  addr_t                    bus_addr [2];
  logic [NumBusErrBits-1:0] bus_err [2];
  logic [NumExtIrqs-1:0]    ext_irqs;
  logic [NumTimerIrqs-1:0]  timer_irqs;
  logic                     irq_valid;
  irq_id_t                  irq_id;
  logic                     irq_ready;
  irq_vec_t                 irq_onehot;

  // Model state with index 0 for the instruction bus
  addr_t    outq [2][$];
  data_t    m_cnt [2];
  addr_t    m_cap [2];
  irq_vec_t m_en;
  logic     m_valid;
  irq_id_t  m_id;
  int       mismatches;
  int       timeouts;

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  core_local_periph u_dut (
    .clk_i          ( clk_i         ),
    .reset_i        ( reset_i       ),
    .cl_req_i       ( cl_req        ),
    .cl_rsp_o       ( cl_rsp        ),
    .instr_req_i    ( bus_req[0]    ),
    .instr_gnt_i    ( bus_gnt[0]    ),
    .instr_rvalid_i ( bus_rvalid[0] ),
    .instr_addr_i   ( bus_addr[0]   ),
    .instr_err_i    ( bus_err[0]    ),
    .data_req_i     ( bus_req[1]    ),
    .data_gnt_i     ( bus_gnt[1]    ),
    .data_rvalid_i  ( bus_rvalid[1] ),
    .data_addr_i    ( bus_addr[1]   ),
    .data_err_i     ( bus_err[1]    ),
    .ext_irqs_i     ( ext_irqs      ),
    .timer_irqs_i   ( timer_irqs    ),
    .irq_valid_o    ( irq_valid     ),
    .irq_id_o       ( irq_id        ),
    .irq_ready_i    ( irq_ready     ),
    .irq_onehot_o   ( irq_onehot    )
  );

  task automatic check_rsp(input string name, input reg_rsp_t exp, input reg_rsp_t act);
    if (act !== exp) begin
      $display("ERR %s: rsp expected %h, actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s: irq valid expected %b, actual %b", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_id(input string name, input irq_id_t exp, input irq_id_t act);
    if (act !== exp) begin
      $display("ERR %s: irq id expected %0d, actual %0d", name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_vec(input string name, input irq_vec_t exp, input irq_vec_t act);
    if (act !== exp) begin
      $display("ERR %s: onehot expected %h, actual %h", name, exp, act);
      mismatches++;
    end
  endtask

  function automatic reg_req_t make_req(logic valid, logic write, addr_t addr, data_t wdata);
    reg_req_t req;
    req.valid = valid;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    return req;
  endfunction

  // Window 0 is irq, 1 instr errors, 2 data errors and -1 unmapped
  function automatic int win_of(addr_t addr);
    addr_t rel;
    rel = addr - PeriphBaseAddr;
    if (rel < 32'h100) return 0;
    if (rel >= 32'h100 && rel < 32'h200) return 1;
    if (rel >= 32'h200 && rel < 32'h300) return 2;
    return -1;
  endfunction

  function automatic irq_vec_t raw_lines(logic [NumExtIrqs-1:0] ext, logic [1:0] timer);
    irq_vec_t raw;
    raw = '0;
    raw[7]  = timer[0];
    raw[16] = timer[0];
    raw[17] = timer[1];
    raw[18] = (m_cnt[0] != '0);
    raw[19] = (m_cnt[1] != '0);
    raw[39:32] = ext;
    return raw;
  endfunction

  function automatic reg_rsp_t expect_rsp(addr_t addr, irq_vec_t raw);
    reg_rsp_t rsp;
    int       w;
    logic [7:0] off;
    w   = win_of(addr);
    off = addr[7:0];
    rsp.ready = 1'b1;
    rsp.error = 1'b0;
    rsp.rdata = '0;
    if (w < 0) begin
      rsp.error = 1'b1;
      rsp.rdata = 32'hBADC_AB1E;
    end else if (w == 0) begin
      if (off == 8'h00) rsp.rdata = m_en[31:0];
      if (off == 8'h04) rsp.rdata = {24'h0, m_en[39:32]};
      if (off == 8'h08) rsp.rdata = raw[31:0];
      if (off == 8'h0C) rsp.rdata = {24'h0, raw[39:32]};
    end else begin
      if (off == 8'h00) rsp.rdata = m_cnt[w-1];
      if (off == 8'h04) rsp.rdata = m_cap[w-1];
    end
    return rsp;
  endfunction

  // Drives one cycle at the rising edge and compares at the falling edge
  task automatic step(input string name, input bit traffic, input bit ack, input reg_req_t acc);
    logic [31:0] r;
    logic        rv [2];
    logic        gn [2];
    addr_t       ad [2];
    logic [1:0]  er [2];
    logic [7:0]  ext;
    logic [1:0]  tim;
    logic        rdy;
    logic        clr;
    logic        hit;
    addr_t       popped;
    irq_vec_t    raw;
    irq_vec_t    pend;
    irq_vec_t    exp_vec;
    irq_id_t     exp_id;
    logic        exp_valid;
    reg_rsp_t    exp_rsp;
    int          w;

    @(posedge clk_i);
    exp_id    = m_id;
    exp_valid = m_valid;
    exp_vec   = '0;
    if (m_valid) begin
      exp_vec[m_id] = 1'b1;
    end
    for (int b = 0; b < 2; b++) begin
      r     = $urandom();
      rv[b] = traffic && (outq[b].size() > 0) && r[0];
      gn[b] = traffic && (outq[b].size() < 2) && r[1];
      ad[b] = $urandom();
      er[b] = (r[3:2] == 2'b00) ? r[6:5] : 2'b00;
      bus_req[b]    <= traffic && (r[1] || r[7]);
      bus_gnt[b]    <= gn[b];
      bus_rvalid[b] <= rv[b];
      bus_addr[b]   <= ad[b];
      bus_err[b]    <= er[b];
    end
    r   = $urandom();
    ext = r[7:0];
    tim = r[9:8];
    rdy = ack && r[10];
    ext_irqs   <= ext;
    timer_irqs <= tim;
    irq_ready  <= rdy;
    cl_req     <= acc;

    raw     = raw_lines(ext, tim);
    exp_rsp = expect_rsp(acc.addr, raw);

    // Highest raw and enabled line is registered at the next edge
    pend = raw & m_en;
    m_id = '0;
    for (int i = 0; i < TotalIrqs; i++) begin
      if (pend[i]) begin
        m_id = irq_id_t'(i);
      end
    end
    m_valid = (pend != '0) && !(m_valid && rdy);

    w = win_of(acc.addr);
    if (acc.valid && acc.write && w == 0) begin
      if (acc.addr[7:0] == 8'h00) m_en[31:0] = acc.wdata;
      if (acc.addr[7:0] == 8'h04) m_en[39:32] = acc.wdata[7:0];
    end
    for (int b = 0; b < 2; b++) begin
      clr = acc.valid && acc.write && (w == b + 1) && (acc.addr[7:0] == 8'h00);
      hit = 1'b0;
      if (rv[b]) begin
        popped = outq[b].pop_front();
        hit    = (er[b] != 2'b00);
        if (hit && m_cnt[b] == '0) begin
          m_cap[b] = popped;
        end
      end
      if (clr) begin
        m_cnt[b] = '0;
      end else if (hit) begin
        m_cnt[b] = m_cnt[b] + 1;
      end
      if (gn[b]) begin
        outq[b].push_back(ad[b]);
      end
    end

    @(negedge clk_i);
    if (acc.valid) begin
      check_rsp(name, exp_rsp, cl_rsp);
    end
    check_valid(name, exp_valid, irq_valid);
    check_id(name, exp_id, irq_id);
    check_vec(name, exp_vec, irq_onehot);
  endtask

  task automatic wait_for_irq(input string name);
    int cycles;
    cycles = 0;
    while (irq_valid !== 1'b1 && cycles < 20) begin
      step(name, 1'b0, 1'b0, make_req(1'b0, 1'b0, '0, '0));
      cycles++;
    end
    if (irq_valid !== 1'b1) begin
      $display("%s: timed out waiting for irq_valid_o to rise", name);
      timeouts++;
    end
  endtask

  initial begin
    logic [31:0] r;
    addr_t       addr;

    r = $urandom(73931);
    mismatches = 0;
    timeouts   = 0;
    m_en       = '0;
    m_valid    = 1'b0;
    m_id       = '0;
    reset_i    <= 1'b1;
    cl_req     <= '0;
    ext_irqs   <= '0;
    timer_irqs <= '0;
    irq_ready  <= 1'b0;
    for (int b = 0; b < 2; b++) begin
      m_cnt[b]      = '0;
      m_cap[b]      = '0;
      bus_req[b]    <= 1'b0;
      bus_gnt[b]    <= 1'b0;
      bus_rvalid[b] <= 1'b0;
      bus_addr[b]   <= '0;
      bus_err[b]    <= '0;
    end
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    // Accesses outside the map
    for (int i = 0; i < 40; i++) begin
      addr = $urandom();
      if (addr - PeriphBaseAddr < 32'h300) begin
        addr = addr ^ 32'h8000_0000;
      end
      r = $urandom();
      step("unmapped", 1'b0, 1'b0, make_req(1'b1, r[0], addr, $urandom()));
    end

    for (int i = 0; i < 300; i++) begin
      r    = $urandom();
      addr = PeriphBaseAddr + (r[0] ? 32'h200 : 32'h100) + {28'h0, r[2:1], 2'b00};
      step("bus_err", 1'b1, 1'b0, make_req(r[3], r[7:4] == 4'h0, addr, $urandom()));
    end

    // Clear both counts and read them back with the raw lines
    step("clear", 1'b0, 1'b0, make_req(1'b1, 1'b1, PeriphBaseAddr + 32'h100, '0));
    step("clear", 1'b0, 1'b0, make_req(1'b1, 1'b1, PeriphBaseAddr + 32'h200, '0));
    step("clear", 1'b0, 1'b0, make_req(1'b1, 1'b0, PeriphBaseAddr + 32'h100, '0));
    step("clear", 1'b0, 1'b0, make_req(1'b1, 1'b0, PeriphBaseAddr + 32'h200, '0));
    step("clear", 1'b0, 1'b0, make_req(1'b1, 1'b0, PeriphBaseAddr + 32'h008, '0));

    for (int i = 0; i < 200; i++) begin
      r    = $urandom();
      addr = PeriphBaseAddr + {28'h0, r[2:1], 2'b00};
      step("irq_sel", 1'b1, 1'b0, make_req(r[3], !r[2], addr, $urandom()));
    end

    step("irq_ack", 1'b0, 1'b0, make_req(1'b1, 1'b1, PeriphBaseAddr, '1));
    step("irq_ack", 1'b0, 1'b0, make_req(1'b1, 1'b1, PeriphBaseAddr + 32'h004, '1));
    wait_for_irq("irq_ack");
    for (int i = 0; i < 200; i++) begin
      r    = $urandom();
      addr = PeriphBaseAddr + {28'h0, r[2:1], 2'b00};
      step("irq_ack", 1'b1, 1'b1, make_req(r[3], 1'b0, addr, '0));
    end

    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/core_local_periph_props.sv
/*
  Interrupt handshake and register bus properties, bound to core_local_periph.
*/
`timescale 1ns/1ps

module core_local_periph_props (
  input logic                    clk_i,
  input logic                    reset_i,
  input cl_regbus_pkg::reg_req_t cl_req_i,
  input cl_regbus_pkg::reg_rsp_t cl_rsp_o,
  input logic                    irq_valid_o,
  input cl_irq_pkg::irq_id_t     irq_id_o,
  input logic                    irq_ready_i,
  input cl_irq_pkg::irq_vec_t    irq_onehot_o
);
  import cl_irq_pkg::*;

  irq_vec_t onehot_exp;

  assign onehot_exp = irq_valid_o ? (irq_vec_t'(1) << irq_id_o) : '0;

  a_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    irq_onehot_o == onehot_exp)
    else $error("irq_onehot_o does not match irq_valid_o and irq_id_o");

  // Valid drops for one cycle after an accepted acknowledge
  a_ack_drop: assert property (@(posedge clk_i) disable iff (reset_i)
    irq_valid_o && irq_ready_i |=> !irq_valid_o)
    else $error("irq_valid_o stayed high after an accepted acknowledge");

  a_same_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    cl_req_i.valid |-> cl_rsp_o.ready)
    else $error("register response not ready in the request cycle");

endmodule

bind core_local_periph core_local_periph_props u_props (
  .clk_i        ( clk_i        ),
  .reset_i      ( reset_i      ),
  .cl_req_i     ( cl_req_i     ),
  .cl_rsp_o     ( cl_rsp_o     ),
  .irq_valid_o  ( irq_valid_o  ),
  .irq_id_o     ( irq_id_o     ),
  .irq_ready_i  ( irq_ready_i  ),
  .irq_onehot_o ( irq_onehot_o )
);

// File: hw/core_local_periph.sv
/*
  Core-local peripheral complex: regbus demux, two bus-error units, interrupt controller.
  The register bus answers in the same cycle; the core's acknowledge drives irq_ready_i.
*/
`timescale 1ns/1ps

module core_local_periph (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  cl_regbus_pkg::reg_req_t              cl_req_i,
  output cl_regbus_pkg::reg_rsp_t              cl_rsp_o,

  // Instruction bus
  input  logic                                 instr_req_i,
  input  logic                                 instr_gnt_i,
  input  logic                                 instr_rvalid_i,
  input  cl_regbus_pkg::addr_t                 instr_addr_i,
  input  logic [cl_irq_pkg::NumBusErrBits-1:0] instr_err_i,

  // Data bus
  input  logic                                 data_req_i,
  input  logic                                 data_gnt_i,
  input  logic                                 data_rvalid_i,
  input  cl_regbus_pkg::addr_t                 data_addr_i,
  input  logic [cl_irq_pkg::NumBusErrBits-1:0] data_err_i,

  // Interrupts
  input  logic [cl_irq_pkg::NumExtIrqs-1:0]    ext_irqs_i,
  input  logic [cl_irq_pkg::NumTimerIrqs-1:0]  timer_irqs_i,
  output logic                                 irq_valid_o,
  output cl_irq_pkg::irq_id_t                  irq_id_o,
  input  logic                                 irq_ready_i,
  output cl_irq_pkg::irq_vec_t                 irq_onehot_o
);
  import cl_regbus_pkg::*;

  reg_req_t [NumPeriphs-1:0] periph_req;
  reg_rsp_t [NumPeriphs-1:0] periph_rsp;
  logic                      instr_err_irq;
  logic                      data_err_irq;

  cl_regbus_demux u_demux (
    .req_i        ( cl_req_i   ),
    .rsp_o        ( cl_rsp_o   ),
    .periph_req_o ( periph_req ),
    .periph_rsp_i ( periph_rsp )
  );

  bus_err_unit u_instr_err (
    .clk_i,
    .reset_i,
    .bus_req_i    ( instr_req_i                ),
    .bus_gnt_i    ( instr_gnt_i                ),
    .bus_rvalid_i ( instr_rvalid_i             ),
    .bus_addr_i   ( instr_addr_i               ),
    .bus_err_i    ( instr_err_i                ),
    .reg_req_i    ( periph_req[IDX_INSTR_ERR] ),
    .reg_rsp_o    ( periph_rsp[IDX_INSTR_ERR] ),
    .err_irq_o    ( instr_err_irq              )
  );

  bus_err_unit u_data_err (
    .clk_i,
    .reset_i,
    .bus_req_i    ( data_req_i                ),
    .bus_gnt_i    ( data_gnt_i                ),
    .bus_rvalid_i ( data_rvalid_i             ),
    .bus_addr_i   ( data_addr_i               ),
    .bus_err_i    ( data_err_i                ),
    .reg_req_i    ( periph_req[IDX_DATA_ERR] ),
    .reg_rsp_o    ( periph_rsp[IDX_DATA_ERR] ),
    .err_irq_o    ( data_err_irq              )
  );

  cl_irq_ctrl u_irq (
    .clk_i,
    .reset_i,
    .ext_irqs_i      ( ext_irqs_i          ),
    .timer_irqs_i    ( timer_irqs_i        ),
    .instr_err_irq_i ( instr_err_irq       ),
    .data_err_irq_i  ( data_err_irq        ),
    .reg_req_i       ( periph_req[IDX_IRQ] ),
    .reg_rsp_o       ( periph_rsp[IDX_IRQ] ),
    .irq_valid_o     ( irq_valid_o         ),
    .irq_id_o        ( irq_id_o            ),
    .irq_ready_i     ( irq_ready_i         ),
    .irq_onehot_o    ( irq_onehot_o        )
  );

endmodule

// File: hw/cl_irq_ctrl.sv
/*
  Simple interrupt controller; priority is the line number, highest wins.
  The selection is registered, so irq_valid_o/irq_id_o lag lines and enables by one cycle.
*/
`timescale 1ns/1ps

module cl_irq_ctrl (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [cl_irq_pkg::NumExtIrqs-1:0]    ext_irqs_i,
  input  logic [cl_irq_pkg::NumTimerIrqs-1:0]  timer_irqs_i,
  input  logic                                 instr_err_irq_i,
  input  logic                                 data_err_irq_i,
  input  cl_regbus_pkg::reg_req_t              reg_req_i,
  output cl_regbus_pkg::reg_rsp_t              reg_rsp_o,
  output logic                                 irq_valid_o,
  output cl_irq_pkg::irq_id_t                  irq_id_o,
  input  logic                                 irq_ready_i,
  output cl_irq_pkg::irq_vec_t                 irq_onehot_o
);
  import cl_regbus_pkg::*;
  import cl_irq_pkg::*;

  irq_vec_t irq_raw;
  irq_vec_t irq_en;
  irq_vec_t irq_pend;
  logic     pend_valid;
  irq_id_t  pend_id;
  logic     irq_valid_q;
  irq_id_t  irq_id_q;
  reg_off_t reg_off;
  logic     reg_wr;

  // Line map, mtip shares timer bit 0
  always_comb begin
    irq_raw                                = '0;
    irq_raw[MtipLine]                      = timer_irqs_i[0];
    irq_raw[TimerLineBase +: NumTimerIrqs] = timer_irqs_i;
    irq_raw[InstrErrLine]                  = instr_err_irq_i;
    irq_raw[DataErrLine]                   = data_err_irq_i;
    irq_raw[ExtLineBase +: NumExtIrqs]     = ext_irqs_i;
  end

  assign irq_pend = irq_raw & irq_en;

  always_comb begin
    pend_valid = 1'b0;
    pend_id    = '0;
    for (int i = 0; i < TotalIrqs; i++) begin
      if (irq_pend[i]) begin
        pend_valid = 1'b1;
        pend_id    = irq_id_t'(i);
      end
    end
  end

  assign reg_off = reg_req_i.addr[RegOffsetW-1:0];
  assign reg_wr  = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_en <= '0;
    end else if (reg_wr) begin
      case (reg_off)
        IrqEnLoReg: irq_en[ExtLineBase-1:0] <= reg_req_i.wdata;
        IrqEnHiReg: irq_en[TotalIrqs-1:ExtLineBase] <= reg_req_i.wdata[NumExtIrqs-1:0];
        default:    irq_en <= irq_en;
      endcase
    end
  end

  // An accepted acknowledge drops valid for one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_valid_q <= 1'b0;
      irq_id_q    <= '0;
    end else begin
      irq_valid_q <= pend_valid && !(irq_valid_q && irq_ready_i);
      irq_id_q    <= pend_id;
    end
  end

  assign irq_valid_o = irq_valid_q;
  assign irq_id_o    = irq_id_q;

  always_comb begin
    irq_onehot_o = '0;
    if (irq_valid_q) begin
      irq_onehot_o[irq_id_q] = 1'b1;
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (reg_off)
      IrqEnLoReg:  reg_rsp_o.rdata = irq_en[ExtLineBase-1:0];
      IrqEnHiReg:  reg_rsp_o.rdata = data_t'(irq_en[TotalIrqs-1:ExtLineBase]);
      IrqRawLoReg: reg_rsp_o.rdata = irq_raw[ExtLineBase-1:0];
      IrqRawHiReg: reg_rsp_o.rdata = data_t'(irq_raw[TotalIrqs-1:ExtLineBase]);
      default:     reg_rsp_o.rdata = '0;
    endcase
  end

endmodule

// File: hw/bus_err_unit.sv
/*
  Watches one request/grant/rvalid bus; at most 2 requests may be outstanding.
  rvalid must come at least one cycle after the matching grant.
*/
`timescale 1ns/1ps

module bus_err_unit (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   bus_req_i,
  input  logic                                   bus_gnt_i,
  input  logic                                   bus_rvalid_i,
  input  cl_regbus_pkg::addr_t                   bus_addr_i,
  input  logic [cl_irq_pkg::NumBusErrBits-1:0]   bus_err_i,
  input  cl_regbus_pkg::reg_req_t                reg_req_i,
  output cl_regbus_pkg::reg_rsp_t                reg_rsp_o,
  output logic                                   err_irq_o
);
  import cl_regbus_pkg::*;

  addr_t    q_addr [2];
  logic     wr_ptr;
  logic     rd_ptr;
  data_t    err_cnt;
  addr_t    err_addr;
  reg_off_t reg_off;
  logic     push;
  logic     pop;
  logic     err_hit;
  logic     cnt_clr;

  assign push    = bus_req_i && bus_gnt_i;
  assign pop     = bus_rvalid_i;
  assign err_hit = pop && (bus_err_i != '0);
  assign reg_off = reg_req_i.addr[RegOffsetW-1:0];
  assign cnt_clr = reg_req_i.valid && reg_req_i.write && (reg_off == ErrCntReg);

  // In-order address queue
  always_ff @(posedge clk_i) begin
    if (push) begin
      q_addr[wr_ptr] <= bus_addr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
    end
  end

  // Clear has priority over a new error
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_cnt  <= '0;
      err_addr <= '0;
    end else begin
      if (cnt_clr) begin
        err_cnt <= '0;
      end else if (err_hit) begin
        err_cnt <= err_cnt + 1'b1;
      end
      if (err_hit && err_cnt == '0) begin
        err_addr <= q_addr[rd_ptr];
      end
    end
  end

  assign err_irq_o = (err_cnt != '0);

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (reg_off)
      ErrCntReg:  reg_rsp_o.rdata = err_cnt;
      ErrAddrReg: reg_rsp_o.rdata = err_addr;
      default:    reg_rsp_o.rdata = '0;
    endcase
  end

endmodule

// File: hw/cl_regbus_demux.sv
/*
  Combinational register bus demux with no back-pressure.
  Addresses outside the three windows get an error response and reach no peripheral.
*/
`timescale 1ns/1ps

module cl_regbus_demux (
  input  cl_regbus_pkg::reg_req_t                                   req_i,
  output cl_regbus_pkg::reg_rsp_t                                   rsp_o,
  output cl_regbus_pkg::reg_req_t [cl_regbus_pkg::NumPeriphs-1:0] periph_req_o,
  input  cl_regbus_pkg::reg_rsp_t [cl_regbus_pkg::NumPeriphs-1:0] periph_rsp_i
);
  import cl_regbus_pkg::*;

  localparam addr_t WinOffset [NumPeriphs] = '{IrqCtrlOffset, InstrErrOffset, DataErrOffset};

  periph_idx_e sel_idx;
  logic        hit;

  // Window match, ordered as periph_idx_e
  always_comb begin
    addr_t win_base;
    hit     = 1'b0;
    sel_idx = IDX_IRQ;
    for (int i = 0; i < NumPeriphs; i++) begin
      win_base = PeriphBaseAddr + WinOffset[i];
      if (req_i.addr >= win_base && req_i.addr < win_base + PeriphRange) begin
        hit     = 1'b1;
        sel_idx = periph_idx_e'(i);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NumPeriphs; i++) begin
      periph_req_o[i]       = req_i;
      periph_req_o[i].valid = req_i.valid && hit && (sel_idx == periph_idx_e'(i));
    end
  end

  always_comb begin
    if (hit) begin
      rsp_o = periph_rsp_i[sel_idx];
    end else begin
      rsp_o.ready = 1'b1;
      rsp_o.error = 1'b1;
      rsp_o.rdata = ErrRespValue;
    end
  end

endmodule

// File: hw/cl_irq_pkg.sv
/*
  Interrupt line map of the core-local complex.
  External lines start at 32; line 21 and all unlisted lines are tied to zero.
*/
package cl_irq_pkg;

  localparam int unsigned NumExtIrqs    = 8;
  localparam int unsigned NumTimerIrqs  = 2;
  localparam int unsigned NumBusErrBits = 2;
  localparam int unsigned TotalIrqs     = 32 + NumExtIrqs;
  localparam int unsigned IrqIdWidth    = 6;

  typedef logic [IrqIdWidth-1:0] irq_id_t;
  typedef logic [TotalIrqs-1:0]  irq_vec_t;

  // Line numbers
  localparam int unsigned MtipLine      = 7;
  localparam int unsigned TimerLineBase = 16;
  localparam int unsigned InstrErrLine  = 18;
  localparam int unsigned DataErrLine   = 19;
  localparam int unsigned ExtLineBase   = 32;

endpackage

// File: hw/cl_regbus_pkg.sv
/*
  Register bus types and the address map of the core-local complex.
  Each window is 0x100 bytes, so only the low RegOffsetW address bits select a register.
*/
package cl_regbus_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned RegOffsetW = 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [RegOffsetW-1:0] reg_off_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    logic  error;
    data_t rdata;
  } reg_rsp_t;

  // Address map
  localparam addr_t PeriphBaseAddr = 32'h0020_0000;
  localparam addr_t IrqCtrlOffset  = 32'h0000_0000;
  localparam addr_t InstrErrOffset = 32'h0000_0100;
  localparam addr_t DataErrOffset  = 32'h0000_0200;
  localparam addr_t PeriphRange    = 32'h0000_0100;

  typedef enum logic [1:0] {
    IDX_IRQ,
    IDX_INSTR_ERR,
    IDX_DATA_ERR
  } periph_idx_e;

  localparam int unsigned NumPeriphs = 3;
  localparam data_t ErrRespValue = 32'hBADC_AB1E;

  // Register offsets inside a window
  localparam reg_off_t ErrCntReg   = 8'h00;
  localparam reg_off_t ErrAddrReg  = 8'h04;
  localparam reg_off_t IrqEnLoReg  = 8'h00;
  localparam reg_off_t IrqEnHiReg  = 8'h04;
  localparam reg_off_t IrqRawLoReg = 8'h08;
  localparam reg_off_t IrqRawHiReg = 8'h0C;

endpackage
